// ==== build.f ====
hdl/nocPkg.sv
hdl/inputUnit.sv
hdl/grantQuota.sv
hdl/switchArbiter.sv
hdl/outputStage.sv
hdl/routerOutputChannel.sv
tb/routerOutputChannelTb.sv

// ==== hdl/grantQuota.sv ====
`timescale 1ns/1ps

module grantQuota
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    granted,
  input  logic    advance,
  input  pktLen_t quota,
  output logic    used
);

  pktLen_t                   count;
  pktLen_t                   effQuota;
  logic [$bits(pktLen_t):0]  countNext;

  // A zero length still lets one flit through.
  assign effQuota  = (quota == '0) ? pktLen_t'(1) : quota;
  assign countNext = {1'b0, count} + advance;

  // Used includes the flit forwarded in this cycle, so the arbiter can
  // hand over the grant at the same edge and no extra flit slips out.
  assign used = (countNext >= {1'b0, effQuota});

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!granted || used)
    begin
      // A new run starts from zero, even when the same port is granted again.
      count <= '0;
    end
    else if (advance)
    begin
      count <= countNext[$bits(pktLen_t)-1:0];
    end
  end

endmodule

// ==== hdl/inputUnit.sv ====
`timescale 1ns/1ps

module inputUnit
  import nocPkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  flit_t   inFlit,
  output logic    inReady,
  input  logic    pop,
  output logic    req,
  output flit_t   headFlit,
  output pktLen_t quota
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign inReady  = !full;
  assign push     = inValid && inReady;
  assign req      = (count != '0);
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // Pointers wrap explicitly so the depth need not be a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        if (wrPtr == PTR_W'(FIFO_DEPTH - 1))
          wrPtr <= '0;
        else
          wrPtr <= wrPtr + 1'b1;
      end
      if (pop)
      begin
        if (rdPtr == PTR_W'(FIFO_DEPTH - 1))
          rdPtr <= '0;
        else
          rdPtr <= rdPtr + 1'b1;
      end
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // The quota follows the most recent head flit accepted, not the one at the queue head.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quota <= '0;
    end
    else if (push && inFlit.id == FLIT_HEAD)
    begin
      quota <= inFlit.payload[$bits(pktLen_t)-1:0];
    end
  end

  // The output stage may only drain this queue while it holds a flit.
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> req)
    else $error("inputUnit: pop on an empty queue");

endmodule

// ==== hdl/nocPkg.sv ====
package nocPkg;

  // Input ports in index order: Local, North, East, West, South.
  localparam int NUM_PORTS = 5;

  typedef logic [2:0] portIdx_t;
  typedef logic [NUM_PORTS-1:0] portMask_t;

  typedef logic [2:0] flitId_t;
  typedef logic [11:0] pktLen_t;
  typedef logic [31:0] payload_t;

  localparam flitId_t FLIT_HEAD = 3'd1;
  localparam flitId_t FLIT_BODY = 3'd2;
  localparam flitId_t FLIT_TAIL = 3'd3;

  // A head flit carries the packet length in the low bits of its payload.
  typedef struct packed {
    flitId_t  id;
    payload_t payload;
  } flit_t;

  // Flit on the output link, tagged with the input port it came from.
  typedef struct packed {
    portIdx_t src;
    flit_t    flit;
  } outFlit_t;

endpackage

// ==== hdl/outputStage.sv ====
`timescale 1ns/1ps

module outputStage
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t grant,
  input  portIdx_t  grantIdx,
  input  portMask_t req,
  input  flit_t     headFlit [NUM_PORTS],
  output portMask_t pop,
  output logic      outValid,
  output outFlit_t  outFlit,
  input  logic      outReady
);

  logic regFree;
  logic popOne;

  // The register can take a new flit when it is empty or drained this cycle.
  assign regFree = !outValid || outReady;

  // A grantee whose queue just ran dry keeps the grant for one more cycle.
  assign popOne = regFree && grant[grantIdx] && req[grantIdx];
  assign pop    = grant & {NUM_PORTS{popOne}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (popOne)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (popOne)
    begin
      outFlit.src  <= grantIdx;
      outFlit.flit <= headFlit[grantIdx];
    end
  end

  // A stalled flit stays on the link until the downstream side accepts it.
  outHold: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outFlit)))
    else $error("outputStage: output flit changed while stalled");

endmodule

// ==== hdl/routerOutputChannel.sv ====
`timescale 1ns/1ps

module routerOutputChannel
  import nocPkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t inValid,
  input  flit_t     inFlit [NUM_PORTS],
  output portMask_t inReady,
  output logic      outValid,
  output outFlit_t  outFlit,
  input  logic      outReady
);

  portMask_t req;
  portMask_t pop;
  portMask_t grant;
  portIdx_t  grantIdx;
  flit_t     headFlit [NUM_PORTS];
  pktLen_t   quota [NUM_PORTS];

  genvar p;
  generate
    for (p = 0; p < NUM_PORTS; p++)
    begin : genPort
      inputUnit #(
        .FIFO_DEPTH (FIFO_DEPTH)
      ) inputUnit_i (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid[p]),
        .inFlit   (inFlit[p]),
        .inReady  (inReady[p]),
        .pop      (pop[p]),
        .req      (req[p]),
        .headFlit (headFlit[p]),
        .quota    (quota[p])
      );
    end
  endgenerate

  switchArbiter switchArbiter_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .pop      (pop),
    .quota    (quota),
    .grant    (grant),
    .grantIdx (grantIdx)
  );

  outputStage outputStage_i (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .grantIdx (grantIdx),
    .req      (req),
    .headFlit (headFlit),
    .pop      (pop),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

endmodule

// ==== hdl/switchArbiter.sv ====
`timescale 1ns/1ps

module switchArbiter
  import nocPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t req,
  input  portMask_t pop,
  input  pktLen_t   quota [NUM_PORTS],
  output portMask_t grant,
  output portIdx_t  grantIdx
);

  typedef enum logic {
    idle,
    busy
  } arbState_t;

  arbState_t state;
  arbState_t nextState;
  portIdx_t  nextIdx;
  portIdx_t  startIdx;
  portIdx_t  candIdx;
  portIdx_t  pickIdx;
  portMask_t used;
  logic      found;
  logic      keep;

  function automatic portIdx_t wrapInc(portIdx_t idx);
    if (idx == portIdx_t'(NUM_PORTS - 1))
      return '0;
    return idx + 1'b1;
  endfunction

  genvar i;
  generate
    for (i = 0; i < NUM_PORTS; i++)
    begin : genQuota
      grantQuota grantQuota_i (
        .clk     (clk),
        .rst     (rst),
        .granted (grant[i]),
        .advance (pop[i]),
        .quota   (quota[i]),
        .used    (used[i])
      );
    end
  endgenerate

  // Round-robin search begins just after the current grantee and wraps
  // around to it last; from idle it begins at the Local port.
  always_comb
  begin
    startIdx = (state == busy) ? wrapInc(grantIdx) : '0;
    found    = 1'b0;
    pickIdx  = '0;
    candIdx  = startIdx;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (!found && req[candIdx])
      begin
        found   = 1'b1;
        pickIdx = candIdx;
      end
      candIdx = wrapInc(candIdx);
    end
  end

  always_comb
  begin
    keep = (state == busy) && req[grantIdx] && !used[grantIdx];
    if (keep)
    begin
      nextState = busy;
      nextIdx   = grantIdx;
    end
    else if (found)
    begin
      nextState = busy;
      nextIdx   = pickIdx;
    end
    else
    begin
      nextState = idle;
      nextIdx   = grantIdx;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= idle;
      grantIdx <= '0;
      grant    <= '0;
    end
    else
    begin
      state    <= nextState;
      grantIdx <= nextIdx;
      if (nextState == busy)
        grant <= portMask_t'(1) << nextIdx;
      else
        grant <= '0;
    end
  end

  // A grant is one-hot and only goes to a port that was requesting when it was decided.
  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & $past(req)) == grant))
    else $error("switchArbiter: grant 0x%0h not one-hot or not requested", grant);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the router output channel testbench with Verilator.
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert \
       --top-module routerOutputChannelTb \
       -f build.f \
  && ./obj_dir/VrouterOutputChannelTb \
  || { echo "simulation failed"; exit 1; }

// ==== tb/routerOutputChannelTb.sv ====
`timescale 1ns/1ps

module routerOutputChannelTb
  import nocPkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int MAX_LEN = 6;
  localparam int PKTS_SINGLE = 8;
  localparam int PKTS_ALL = 8;
  localparam int PKTS_STALL = 4;
  localparam int MAX_FLITS = MAX_LEN * (PKTS_SINGLE + NUM_PORTS * (PKTS_ALL + PKTS_STALL));
  localparam int WATCHDOG_CYCLES = MAX_FLITS * 40 + 1000;

  logic      clk;
  logic      rst;
  portMask_t inValid;
  flit_t     inFlit [NUM_PORTS];
  portMask_t inReady;
  logic      outValid;
  outFlit_t  outFlit;
  logic      outReady;

  int pktsLeft [NUM_PORTS];
  int flitsLeft [NUM_PORTS];
  int seqNum [NUM_PORTS];

  // Reference model state, describing the DUT just before the edge being processed.
  flit_t     sentQ [NUM_PORTS][$];
  int        occ [NUM_PORTS];
  pktLen_t   tbQuota [NUM_PORTS];
  logic      dropped [NUM_PORTS];
  logic      idleBefore;
  int        lastSrc;
  int        runCount;
  logic      lastUsed;
  logic      expectPending;
  portIdx_t  expectSrc;
  string     expectName;
  portMask_t prevAccept;
  flit_t     prevFlit [NUM_PORTS];
  logic      prevRegFree;
  logic      prevStall;
  outFlit_t  prevOut;

  // Results are computed at the rising edge and checked at the falling edge.
  logic        rstWindow = 1'b0;
  logic        ordHit = 1'b0;
  logic [63:0] ordExp;
  logic [63:0] ordAct;
  logic        srcHit = 1'b0;
  logic [63:0] srcExp;
  logic [63:0] srcAct;
  string       srcName;
  logic        holdHit = 1'b0;
  logic [63:0] holdExp;
  logic [63:0] holdAct;

  routerOutputChannel #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) routerOutputChannel_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic reportMismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "stopped after a failed check");
  endtask

  task automatic abortRun(string what);
    $display("ERROR: %s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped after an error");
  endtask

  function automatic int effQuota(pktLen_t q);
    return (q == '0) ? 1 : int'(q);
  endfunction

  // First port holding flits in cyclic order after the given one.
  function automatic int cyclicPick(int from);
    int c;
    for (int k = 1; k <= NUM_PORTS; k++)
    begin
      c = (from + k) % NUM_PORTS;
      if (occ[c] > 0)
        return c;
    end
    return -1;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++)
      n += sentQ[p].size();
    return n;
  endfunction

  // Packets are a head, body flits and a tail; the sequence number sits above the length bits.
  function automatic flit_t nextFlit(int p);
    flit_t f;
    int    len;
    if (flitsLeft[p] == 0)
    begin
      len = 1 + int'($urandom % MAX_LEN);
      flitsLeft[p] = len;
      pktsLeft[p]--;
      f.id = FLIT_HEAD;
      f.payload = {20'(seqNum[p]), pktLen_t'(len)};
    end
    else
    begin
      f.id = (flitsLeft[p] == 1) ? FLIT_TAIL : FLIT_BODY;
      f.payload = {20'(seqNum[p]), pktLen_t'(flitsLeft[p])};
    end
    flitsLeft[p]--;
    seqNum[p]++;
    return f;
  endfunction

  always @(posedge clk)
  begin : model
    logic load;
    int   src;
    int   total;
    int   pick;
    ordHit = 1'b0;
    srcHit = 1'b0;
    holdHit = 1'b0;
    rstWindow = rst;
    if (rst)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        occ[p] = 0;
        tbQuota[p] = '0;
        dropped[p] = 1'b1;
        sentQ[p].delete();
      end
      idleBefore = 1'b1;
      lastSrc = -1;
      runCount = 0;
      lastUsed = 1'b0;
      expectPending = 1'b0;
      prevAccept = '0;
      prevRegFree = 1'b0;
      prevStall = 1'b0;
    end
    else
    begin
      load = prevRegFree && outValid;
      src = int'(outFlit.src);
      total = 0;
      for (int p = 0; p < NUM_PORTS; p++)
        total += occ[p];
      if (idleBefore && total > 0)
      begin
        pick = cyclicPick(NUM_PORTS - 1);
        expectPending = 1'b1;
        expectSrc = portIdx_t'(pick);
        expectName = "first grant";
      end
      if (prevStall)
      begin
        holdHit = 1'b1;
        holdExp = 64'({1'b1, prevOut});
        holdAct = 64'({outValid, outFlit});
      end
      if (load && (src >= NUM_PORTS || sentQ[src].size() == 0))
        abortRun("output flit from a port with no flit outstanding");
      else if (load)
      begin
        ordHit = 1'b1;
        ordExp = 64'({portIdx_t'(src), sentQ[src][0]});
        ordAct = 64'(outFlit);
        sentQ[src].pop_front();
        if (expectPending)
        begin
          srcHit = 1'b1;
          srcExp = 64'(expectSrc);
          srcAct = 64'(src);
          srcName = expectName;
          expectPending = 1'b0;
        end
        if (src == lastSrc && !lastUsed && !dropped[src])
          runCount++;
        else
          runCount = 1;
        lastUsed = (runCount >= effQuota(tbQuota[src]));
        lastSrc = src;
        dropped[src] = 1'b0;
        if (lastUsed)
        begin
          pick = cyclicPick(src);
          if (pick >= 0 && pick != src)
          begin
            expectPending = 1'b1;
            expectSrc = portIdx_t'(pick);
            expectName = "quota handover";
          end
        end
      end
      else if (lastSrc >= 0 && !lastUsed && !dropped[lastSrc]
               && runCount >= effQuota(tbQuota[lastSrc]))
      begin
        // A newer head flit with a shorter length ends the run while no flit moves.
        lastUsed = 1'b1;
      end
      idleBefore = (total == 0);
      if (load)
        occ[src]--;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (prevAccept[p])
        begin
          occ[p]++;
          sentQ[p].push_back(prevFlit[p]);
          if (prevFlit[p].id == FLIT_HEAD)
            tbQuota[p] = prevFlit[p].payload[11:0];
        end
        if (occ[p] == 0)
          dropped[p] = 1'b1;
      end
      prevAccept = inValid & inReady;
      prevFlit = inFlit;
      prevRegFree = !outValid || outReady;
      prevStall = outValid && !outReady;
      prevOut = outFlit;
    end
  end

  resetCheck: assert property (@(negedge clk) rstWindow |-> (!outValid && inReady == '1))
    else reportMismatch("reset", 64'({1'b0, 5'h1f}), 64'({outValid, inReady}));
  orderCheck: assert property (@(negedge clk) ordHit |-> (ordAct == ordExp))
    else reportMismatch("ordering", ordExp, ordAct);
  grantCheck: assert property (@(negedge clk) srcHit |-> (srcAct == srcExp))
    else reportMismatch(srcName, srcExp, srcAct);
  holdCheck: assert property (@(negedge clk) holdHit |-> (holdAct == holdExp))
    else reportMismatch("back-pressure hold", holdExp, holdAct);

  task automatic runPhase(portMask_t active, int pkts, int stallAt);
    int cycle;
    int quiet;
    logic allSent;
    for (int p = 0; p < NUM_PORTS; p++)
      pktsLeft[p] = active[p] ? pkts : 0;
    cycle = 0;
    quiet = 0;
    while (quiet < 3)
    begin
      @(posedge clk);
      allSent = 1'b1;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (flitsLeft[p] > 0 || pktsLeft[p] > 0)
          allSent = 1'b0;
        if (!inValid[p] || inReady[p])
        begin
          if ((flitsLeft[p] > 0 || pktsLeft[p] > 0) && ($urandom % 4) != 0)
          begin
            inValid[p] <= 1'b1;
            inFlit[p] <= nextFlit(p);
          end
          else
            inValid[p] <= 1'b0;
        end
      end
      if (stallAt >= 0 && cycle >= stallAt && cycle < stallAt + 20)
        outReady <= 1'b0;
      else
        outReady <= (($urandom % 10) < 7);
      if (allSent && inValid == '0 && outstanding() == 0 && !outValid)
        quiet++;
      else
        quiet = 0;
      cycle++;
    end
  endtask

  initial
  begin
    void'($urandom(32'h9607_b192));
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inFlit[p] = '0;
      pktsLeft[p] = 0;
      flitsLeft[p] = 0;
      seqNum[p] = 0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // East alone, then every port, then every port with a long output stall.
    runPhase(5'b00100, PKTS_SINGLE, -1);
    runPhase('1, PKTS_ALL, -1);
    runPhase('1, PKTS_STALL, 15);
    if (outstanding() != 0 || outValid)
    begin
      $display("ERROR: flits still outstanding at the end of the run");
      $display("TEST FAILED");
      $fatal(1, "flits lost");
    end
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abortRun("watchdog timeout, the DUT stopped delivering flits");
  end

endmodule
